// ==== sources.f ====
+incdir+.
rv_front_pkg.sv
stage_queue.sv
inst_fetch.sv
inst_decoder.sv
rv_front_top.sv
tb_rv_front.sv

// ==== Makefile ====
TOP := tb_rv_front

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module rv_front_top
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation failed, see sim.log"; exit 1; fi
	@if ! grep -q "Test OK" sim.log; then echo "No pass line in sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// Extra weight on the ALU classes.
function automatic logic [6:0] pick_opcode(input logic [3:0] k);
    case (k)
        4'd0, 4'd11:  return `OPCODE_RTYPE;
        4'd2:         return `OPCODE_LOAD;
        4'd3:         return `OPCODE_STORE;
        4'd4, 4'd12:  return `OPCODE_BRANCH;
        4'd5:         return `OPCODE_JAL;
        4'd6:         return `OPCODE_JALR;
        4'd7:         return `OPCODE_LUI;
        4'd8:         return `OPCODE_AUIPC;
        4'd9:         return `OPCODE_SYSTEM;
        4'd10:        return `OPCODE_FENCE;
        default:      return `OPCODE_ITYPE;
    endcase
endfunction

// Word stored at a pc, recomputed from the pc alone.
function automatic logic [31:0] word_at(input logic [31:0] pc);
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] w;
    s1 = lcg_step(lcg_step(32'd75 ^ pc));
    s2 = lcg_step(s1);
    w  = {s1[31:7], 7'd0};
    case (s2[31:28])
        4'd0: w[6:0] = {s2[20:18], 4'b1011};          // Custom and reserved space.
        4'd1: w[6:0] = {s2[20:16], 1'b0, s2[15]};     // Not a 32-bit encoding.
        4'd2: begin
            w[6:0]   = `OPCODE_ITYPE;
            w[14:12] = s2[17] ? 3'b101 : 3'b001;
            w[31]    = s2[16];
            if (!s2[16]) w[27] = 1'b1;                 // Always a stray funct7 bit.
        end
        default: begin
            w[6:0] = pick_opcode(s2[27:24]);
            if (w[6:0] == `OPCODE_ITYPE && w[13:12] == 2'b01) begin
                w[31]    = 1'b0;
                w[29:25] = 5'd0;
            end
        end
    endcase
    return w;
endfunction

function automatic rv_front_pkg::decoded_t decode_ref(input logic [31:0] pc,
                                                      input logic [31:0] w);
    rv_front_pkg::decoded_t d;
    d        = '0;
    d.pc     = pc;
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.rd     = w[11:7];
    d.funct3 = w[14:12];
    case (w[6:0])
        `OPCODE_RTYPE:  d.opc[`OPC_RTYPE]  = 1'b1;
        `OPCODE_ITYPE:  d.opc[`OPC_ITYPE]  = 1'b1;
        `OPCODE_LOAD:   d.opc[`OPC_LOAD]   = 1'b1;
        `OPCODE_STORE:  d.opc[`OPC_STORE]  = 1'b1;
        `OPCODE_BRANCH: d.opc[`OPC_BRANCH] = 1'b1;
        `OPCODE_JAL:    d.opc[`OPC_JAL]    = 1'b1;
        `OPCODE_JALR:   d.opc[`OPC_JALR]   = 1'b1;
        `OPCODE_LUI:    d.opc[`OPC_LUI]    = 1'b1;
        `OPCODE_AUIPC:  d.opc[`OPC_AUIPC]  = 1'b1;
        `OPCODE_SYSTEM: d.opc[`OPC_SYSTEM] = 1'b1;
        `OPCODE_FENCE:  d.opc[`OPC_FENCE]  = 1'b1;
        default: d.exc.illegal_opcode = 1'b1;
    endcase
    if (d.opc[`OPC_RTYPE] || d.opc[`OPC_ITYPE]) begin
        case (d.funct3)
            3'b000:  d.alu[(d.opc[`OPC_RTYPE] && w[30]) ? `ALU_SUB : `ALU_ADD] = 1'b1;
            3'b001:  d.alu[`ALU_SLL] = 1'b1;
            3'b010:  d.alu[`ALU_SLT] = 1'b1;
            3'b011:  d.alu[`ALU_SLTU] = 1'b1;
            3'b100:  d.alu[`ALU_XOR] = 1'b1;
            3'b101:  d.alu[w[30] ? `ALU_SRA : `ALU_SRL] = 1'b1;
            3'b110:  d.alu[`ALU_OR] = 1'b1;
            default: d.alu[`ALU_AND] = 1'b1;
        endcase
    end else if (d.opc[`OPC_BRANCH]) begin
        case (d.funct3)
            3'b000:  d.alu[`ALU_EQ] = 1'b1;
            3'b001:  d.alu[`ALU_NEQ] = 1'b1;
            3'b100:  d.alu[`ALU_LT] = 1'b1;
            3'b101:  d.alu[`ALU_GE] = 1'b1;
            3'b110:  d.alu[`ALU_LTU] = 1'b1;
            3'b111:  d.alu[`ALU_GEU] = 1'b1;
            default: d.alu = '0;                       // Reserved branch codes.
        endcase
    end else begin
        d.alu[`ALU_ADD] = 1'b1;
    end
    if (d.opc[`OPC_ITYPE] || d.opc[`OPC_LOAD] || d.opc[`OPC_JALR])
        d.imm = 32'($signed(w[31:20]));
    else if (d.opc[`OPC_STORE])
        d.imm = 32'($signed({w[31:25], w[11:7]}));
    else if (d.opc[`OPC_BRANCH])
        d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    else if (d.opc[`OPC_JAL])
        d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    else if (d.opc[`OPC_LUI] || d.opc[`OPC_AUIPC])
        d.imm = {w[31:12], 12'h000};
    else if (d.opc[`OPC_SYSTEM] || d.opc[`OPC_FENCE])
        d.imm = {20'h00000, w[31:20]};                // Zero extended.
    d.exc.illegal_shift = d.opc[`OPC_ITYPE] && w[13:12] == 2'b01
                          && (w[31] || w[29:25] != 5'd0);
    return d;
endfunction

`endif

// ==== tb_rv_front.sv ====
`default_nettype none
`include "rv_front_consts.svh"

module tb_rv_front;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_DELIVERIES = 2000;
    localparam int CLK_PERIOD     = 8;

    logic                       d_clk = 1'b0;
    logic                       d_rst = 1'b0;
    logic                       redirect = 1'b0;
    logic [`RV_XLEN-1:0]        redirect_pc = '0;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic [`RV_XLEN-1:0]        wb_adr;
    logic [`RV_XLEN-1:0]        wb_dat_i = '0;
    logic                       wb_ack = 1'b0;
    logic                       dec_valid;
    logic                       dec_ready = 1'b0;
    logic [`RV_XLEN-1:0]        dec_pc;
    logic [4:0]                 dec_rs1;
    logic [4:0]                 dec_rs2;
    logic [4:0]                 dec_rd;
    logic [2:0]                 dec_funct3;
    logic [`RV_XLEN-1:0]        dec_imm;
    rv_front_pkg::alu_onehot_t  dec_alu;
    rv_front_pkg::opc_onehot_t  dec_opc;
    rv_front_pkg::exc_t         dec_exc;

    // Memory model state.
    logic [31:0]  mem_rng = 32'd75;
    logic [31:0]  fetch_exp = '0;
    logic [31:0]  held_adr = '0;
    logic         mem_busy = 1'b0;
    int           wait_left = 0;

    // Consumer and redirect state.
    logic [31:0]  drv_rng = 32'd75;
    logic [31:0]  exp_pc = '0;
    int           delivered = 0;
    int           since_redirect = 0;
    int           redirect_gap = 30;

    `include "tb_decode_model.svh"

    rv_front_top DUT (
        .d_clk       (d_clk),
        .d_rst       (d_rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_pc      (dec_pc),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_funct3  (dec_funct3),
        .dec_imm     (dec_imm),
        .dec_alu     (dec_alu),
        .dec_opc     (dec_opc),
        .dec_exc     (dec_exc)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic compare_addr(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
                                input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic compare_decoded(input rv_front_pkg::decoded_t got,
                                   input rv_front_pkg::decoded_t exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0d ns: word %h at pc %h decoded to %h, expected %h",
                               $time, word_at(exp.pc), exp.pc, got, exp));
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) d_clk = ~d_clk;
    end

    initial begin
        repeat (10) @(posedge d_clk);
        d_rst <= 1'b1;
        wait (delivered >= NUM_DELIVERIES);
        @(posedge d_clk);
        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (NUM_DELIVERIES * 40) @(posedge d_clk);
        stop_run("Watchdog expired: the front end stopped delivering instructions.");
    end

    // Wishbone memory with 0 to 3 wait states.
    always @(posedge d_clk) begin
        if (d_rst) begin
            if (wb_stb && !wb_cyc) stop_run("Bus error: wb_stb is high while wb_cyc is low.");
            if (wb_ack) begin
                wb_ack <= 1'b0;
            end else if (wb_stb) begin
                if (!mem_busy) begin
                    compare_addr(wb_adr, fetch_exp, "fetch address");
                    fetch_exp = wb_adr + 32'd4;
                    held_adr  = wb_adr;
                    mem_rng   = lcg_step(mem_rng ^ wb_adr);
                    wait_left = int'(mem_rng[31:30]);
                    mem_busy  = 1'b1;
                end else begin
                    compare_addr(wb_adr, held_adr, "address held in a wait state");
                end
                if (wait_left == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_i <= word_at(wb_adr);
                    mem_busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end
            if (redirect) fetch_exp = redirect_pc;      // Cycles seen this edge predate it.
        end
    end

    // Consumer side: check deliveries, then drive ready and redirects.
    always @(posedge d_clk) begin
        rv_front_pkg::decoded_t got;
        if (d_rst) begin
            if (dec_valid && dec_ready) begin
                got = {dec_pc, dec_rs1, dec_rs2, dec_rd, dec_funct3, dec_imm,
                       dec_alu, dec_opc, dec_exc};
                compare_addr(dec_pc, exp_pc, "delivered pc");
                compare_decoded(got, decode_ref(exp_pc, word_at(exp_pc)));
                exp_pc = exp_pc + 32'd4;
                delivered++;
                since_redirect++;
            end
            if (redirect) exp_pc = redirect_pc;
            drv_rng = lcg_step(drv_rng);
            dec_ready <= (drv_rng[31:24] < 8'd179);     // About 70 percent.
            if (since_redirect >= redirect_gap) begin
                drv_rng = lcg_step(drv_rng);
                redirect    <= 1'b1;
                redirect_pc <= {drv_rng[31:2], 2'b00};
                since_redirect = 0;
                redirect_gap   = 24 + int'(drv_rng[13:9]);
            end else begin
                redirect <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rv_front_top.sv ====
`default_nettype none
`include "rv_front_consts.svh"

module rv_front_top (
    input  wire logic                        d_clk,
    input  wire logic                        d_rst,
    input  wire logic                        redirect,
    input  wire logic [`RV_XLEN-1:0]         redirect_pc,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic [`RV_XLEN-1:0]              wb_adr,
    input  wire logic [`RV_XLEN-1:0]         wb_dat_i,
    input  wire logic                        wb_ack,
    output logic                             dec_valid,
    input  wire logic                        dec_ready,
    output logic [`RV_XLEN-1:0]              dec_pc,
    output logic [4:0]                       dec_rs1,
    output logic [4:0]                       dec_rs2,
    output logic [4:0]                       dec_rd,
    output logic [2:0]                       dec_funct3,
    output logic [`RV_XLEN-1:0]              dec_imm,
    output rv_front_pkg::alu_onehot_t        dec_alu,
    output rv_front_pkg::opc_onehot_t        dec_opc,
    output rv_front_pkg::exc_t               dec_exc
);

    logic                        fetch_valid;
    rv_front_pkg::fetch_item_t   fetch_item;
    logic                        fetch_ready;
    logic [1:0]                  fetch_count;
    logic                        raw_valid;
    rv_front_pkg::fetch_item_t   raw_item;
    logic                        raw_ready;
    logic                        dcd_valid;
    rv_front_pkg::decoded_t      dcd_item;
    logic                        dcd_ready;
    logic                        issue_ready;
    rv_front_pkg::decoded_t      issue_item;

    inst_fetch u_fetch (
        .d_clk       (d_clk),
        .d_rst       (d_rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .item_valid  (fetch_valid),
        .item        (fetch_item),
        .queue_count (fetch_count)
    );

    stage_queue #(.payload_t(rv_front_pkg::fetch_item_t)) u_fetch_q (
        .d_clk      (d_clk),
        .d_rst      (d_rst),
        .flush      (redirect),
        .push_valid (fetch_valid),
        .push_data  (fetch_item),
        .push_ready (fetch_ready),
        .pop_valid  (raw_valid),
        .pop_data   (raw_item),
        .pop_ready  (raw_ready),
        .count      (fetch_count)
    );

    inst_decoder u_decoder (
        .d_clk     (d_clk),
        .d_rst     (d_rst),
        .flush     (redirect),
        .in_valid  (raw_valid),
        .in_item   (raw_item),
        .in_ready  (raw_ready),
        .out_valid (dcd_valid),
        .out_item  (dcd_item),
        .out_ready (dcd_ready)
    );

    stage_queue #(.payload_t(rv_front_pkg::decoded_t)) u_issue_q (
        .d_clk      (d_clk),
        .d_rst      (d_rst),
        .flush      (redirect),
        .push_valid (dcd_valid),
        .push_data  (dcd_item),
        .push_ready (issue_ready),
        .pop_valid  (dec_valid),
        .pop_data   (issue_item),
        .pop_ready  (dec_ready),
        .count      ()
    );

    // Decoder holds its result while the issue queue is full.
    assign dcd_ready = issue_ready;

    assign dec_pc     = issue_item.pc;
    assign dec_rs1    = issue_item.rs1;
    assign dec_rs2    = issue_item.rs2;
    assign dec_rd     = issue_item.rd;
    assign dec_funct3 = issue_item.funct3;
    assign dec_imm    = issue_item.imm;
    assign dec_alu    = issue_item.alu;
    assign dec_opc    = issue_item.opc;
    assign dec_exc    = issue_item.exc;

    // Fetch never pushes into a full queue, since it checks the count first.
    a_fetch_fits: assert property (@(posedge d_clk) disable iff (!d_rst)
        fetch_valid |-> fetch_ready);

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
`default_nettype none
`include "rv_front_consts.svh"

module inst_decoder (
    input  wire logic                        d_clk,
    input  wire logic                        d_rst,
    input  wire logic                        flush,
    input  wire logic                        in_valid,
    input  wire rv_front_pkg::fetch_item_t   in_item,
    output logic                             in_ready,
    output logic                             out_valid,
    output rv_front_pkg::decoded_t           out_item,
    input  wire logic                        out_ready
);

    logic [`RV_XLEN-1:0]        instr;
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic                       accept;
    logic [`RV_XLEN-1:0]        imm_d;
    rv_front_pkg::alu_onehot_t  alu_d;
    rv_front_pkg::opc_onehot_t  opc_d;
    rv_front_pkg::exc_t         exc_d;
    rv_front_pkg::decoded_t     dec_d;

    assign instr  = in_item.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        opc_d              = '0;
        opc_d[`OPC_RTYPE]  = (opcode == `OPCODE_RTYPE);
        opc_d[`OPC_ITYPE]  = (opcode == `OPCODE_ITYPE);
        opc_d[`OPC_LOAD]   = (opcode == `OPCODE_LOAD);
        opc_d[`OPC_STORE]  = (opcode == `OPCODE_STORE);
        opc_d[`OPC_BRANCH] = (opcode == `OPCODE_BRANCH);
        opc_d[`OPC_JAL]    = (opcode == `OPCODE_JAL);
        opc_d[`OPC_JALR]   = (opcode == `OPCODE_JALR);
        opc_d[`OPC_LUI]    = (opcode == `OPCODE_LUI);
        opc_d[`OPC_AUIPC]  = (opcode == `OPCODE_AUIPC);
        opc_d[`OPC_SYSTEM] = (opcode == `OPCODE_SYSTEM);
        opc_d[`OPC_FENCE]  = (opcode == `OPCODE_FENCE);

        exc_d.illegal_opcode = ~|opc_d;
        // Shamt is 5 bits; funct7 may only carry bit 30.
        exc_d.illegal_shift  = opc_d[`OPC_ITYPE]
                             && (funct3 == `FUNCT3_SLL || funct3 == `FUNCT3_SRA)
                             && (instr[31] || |instr[29:25]);
    end

    always_comb begin
        alu_d = '0;
        if (opc_d[`OPC_RTYPE] || opc_d[`OPC_ITYPE]) begin
            if (funct3 == `FUNCT3_ADD) begin
                if (opc_d[`OPC_RTYPE] && instr[30]) begin
                    alu_d[`ALU_SUB] = 1'b1;
                end else begin
                    alu_d[`ALU_ADD] = 1'b1;     // Immediate form has no sub.
                end
            end
            alu_d[`ALU_SLT]  = (funct3 == `FUNCT3_SLT);
            alu_d[`ALU_SLTU] = (funct3 == `FUNCT3_SLTU);
            alu_d[`ALU_XOR]  = (funct3 == `FUNCT3_XOR);
            alu_d[`ALU_OR]   = (funct3 == `FUNCT3_OR);
            alu_d[`ALU_AND]  = (funct3 == `FUNCT3_AND);
            alu_d[`ALU_SLL]  = (funct3 == `FUNCT3_SLL);
            alu_d[`ALU_SRL]  = (funct3 == `FUNCT3_SRA) && !instr[30];
            alu_d[`ALU_SRA]  = (funct3 == `FUNCT3_SRA) && instr[30];
        end else if (opc_d[`OPC_BRANCH]) begin
            alu_d[`ALU_EQ]   = (funct3 == `FUNCT3_EQ);
            alu_d[`ALU_NEQ]  = (funct3 == `FUNCT3_NEQ);
            alu_d[`ALU_LT]   = (funct3 == `FUNCT3_LT);
            alu_d[`ALU_GE]   = (funct3 == `FUNCT3_GE);
            alu_d[`ALU_LTU]  = (funct3 == `FUNCT3_LTU);
            alu_d[`ALU_GEU]  = (funct3 == `FUNCT3_GEU);
        end else begin
            alu_d[`ALU_ADD] = 1'b1;             // Address and upper-immediate sums.
        end
    end

    always_comb begin
        case (opcode)
            `OPCODE_ITYPE, `OPCODE_JALR, `OPCODE_LOAD: begin
                imm_d = {{20{instr[31]}}, instr[31:20]};
            end
            `OPCODE_STORE: begin
                imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            `OPCODE_BRANCH: begin
                imm_d = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            `OPCODE_JAL: begin
                imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            `OPCODE_LUI, `OPCODE_AUIPC: begin
                imm_d = {instr[31:12], 12'b0};
            end
            `OPCODE_SYSTEM, `OPCODE_FENCE: begin
                imm_d = {20'b0, instr[31:20]};  // CSR number or fence bits, unsigned.
            end
            default: begin
                imm_d = '0;
            end
        endcase
    end

    always_comb begin
        dec_d.pc     = in_item.pc;
        dec_d.rs1    = instr[19:15];
        dec_d.rs2    = instr[24:20];
        dec_d.rd     = instr[11:7];
        dec_d.funct3 = funct3;
        dec_d.imm    = imm_d;
        dec_d.alu    = alu_d;
        dec_d.opc    = opc_d;
        dec_d.exc    = exc_d;
    end

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge d_clk) begin
        if (accept) out_item <= dec_d;
    end

    // A stalled result stays put until taken.
    a_hold_on_stall: assert property (@(posedge d_clk) disable iff (!d_rst)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_item)));

endmodule

`default_nettype wire

// ==== inst_fetch.sv ====
`default_nettype none
`include "rv_front_consts.svh"

module inst_fetch (
    input  wire logic                  d_clk,
    input  wire logic                  d_rst,
    input  wire logic                  redirect,
    input  wire logic [`RV_XLEN-1:0]   redirect_pc,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic [`RV_XLEN-1:0]        wb_adr,
    input  wire logic [`RV_XLEN-1:0]   wb_dat_i,
    input  wire logic                  wb_ack,
    output logic                       item_valid,
    output rv_front_pkg::fetch_item_t  item,
    input  wire logic [1:0]            queue_count
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DROP     // Cycle still open after a redirect.
    } state_t;

    state_t               state;
    logic [`RV_XLEN-1:0]  pc;
    logic                 start;

    // Only one word is ever in flight, so the queue count in idle is exact.
    assign start = (state == ST_IDLE) && !redirect && (queue_count < 2'(`QUEUE_DEPTH));

    assign wb_cyc = (state != ST_IDLE);
    assign wb_stb = (state == ST_BUSY) || (state == ST_DROP);

    assign item_valid = (state == ST_BUSY) && wb_ack && !redirect;
    assign item.pc    = wb_adr;
    assign item.instr = wb_dat_i;

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            state  <= ST_IDLE;
            pc     <= '0;
            wb_adr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        wb_adr <= pc;
                        state  <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (wb_ack) begin
                        state <= ST_IDLE;
                    end else if (redirect) begin
                        state <= ST_DROP;       // Finish the cycle, discard the word.
                    end
                end
                ST_DROP: begin
                    if (wb_ack) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase

            if (redirect) begin
                pc <= redirect_pc;
            end else if (start) begin
                pc <= pc + `RV_XLEN'd4;
            end
        end
    end

    // Wishbone classic: request held with a steady address until ack.
    a_wb_hold: assert property (@(posedge d_clk) disable iff (!d_rst)
        (wb_stb && !wb_ack) |=> (wb_stb && wb_cyc && $stable(wb_adr)));

endmodule

`default_nettype wire

// ==== stage_queue.sv ====
`default_nettype none
`include "rv_front_consts.svh"

module stage_queue #(
    parameter type payload_t = logic
) (
    input  wire logic     d_clk,
    input  wire logic     d_rst,
    input  wire logic     flush,
    input  wire logic     push_valid,
    input  wire payload_t push_data,
    output logic          push_ready,
    output logic          pop_valid,
    output payload_t      pop_data,
    input  wire logic     pop_ready,
    output logic [1:0]    count
);

    localparam int AW = $clog2(`QUEUE_DEPTH);

    payload_t       mem [`QUEUE_DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic           do_push;
    logic           do_pop;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
        return (p == AW'(`QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push_ready = (count < 2'(`QUEUE_DEPTH));
    assign pop_valid  = (count != 2'd0);
    assign pop_data   = mem[rd_ptr];
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 2'd0;
        end else if (flush) begin
            wr_ptr <= '0;                       // Drops both entries.
            rd_ptr <= '0;
            count  <= 2'd0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop) rd_ptr <= ptr_next(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge d_clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    // A push offered to a full queue leaves it untouched.
    a_no_push_when_full: assert property (@(posedge d_clk) disable iff (!d_rst)
        (!flush && push_valid && count == 2'(`QUEUE_DEPTH) && !do_pop)
        |=> (count == 2'(`QUEUE_DEPTH) && $stable(wr_ptr)));

endmodule

`default_nettype wire

// ==== rv_front_pkg.sv ====
`default_nettype none
`include "rv_front_consts.svh"

package rv_front_pkg;

    typedef logic [`RV_ALU_WIDTH-1:0] alu_onehot_t;
    typedef logic [`RV_OPC_WIDTH-1:0] opc_onehot_t;

    typedef struct packed {
        logic illegal_opcode;   // No class matched.
        logic illegal_shift;    // Shift immediate with stray funct7 bits.
    } exc_t;

    // Raw word as it leaves the bus.
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } fetch_item_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [2:0]          funct3;
        logic [`RV_XLEN-1:0] imm;
        alu_onehot_t         alu;
        opc_onehot_t         opc;
        exc_t                exc;
    } decoded_t;

endpackage

`default_nettype wire

// ==== rv_front_consts.svh ====
`ifndef RV_FRONT_CONSTS_SVH
`define RV_FRONT_CONSTS_SVH

`define RV_XLEN       32
`define RV_ALU_WIDTH  16
`define RV_OPC_WIDTH  11
`define QUEUE_DEPTH   2

// Bit positions in the one-hot ALU field.
`define ALU_ADD   0
`define ALU_SUB   1
`define ALU_SLT   2
`define ALU_SLTU  3
`define ALU_XOR   4
`define ALU_OR    5
`define ALU_AND   6
`define ALU_SLL   7
`define ALU_SRL   8
`define ALU_SRA   9
`define ALU_EQ    10
`define ALU_NEQ   11
`define ALU_LT    12
`define ALU_LTU   13
`define ALU_GE    14
`define ALU_GEU   15

// Bit positions in the one-hot opcode class field.
`define OPC_RTYPE   0
`define OPC_ITYPE   1
`define OPC_LOAD    2
`define OPC_STORE   3
`define OPC_BRANCH  4
`define OPC_JAL     5
`define OPC_JALR    6
`define OPC_LUI     7
`define OPC_AUIPC   8
`define OPC_SYSTEM  9
`define OPC_FENCE   10

`define OPCODE_RTYPE   7'b0110011
`define OPCODE_ITYPE   7'b0010011
`define OPCODE_LOAD    7'b0000011
`define OPCODE_STORE   7'b0100011
`define OPCODE_BRANCH  7'b1100011
`define OPCODE_JAL     7'b1101111
`define OPCODE_JALR    7'b1100111
`define OPCODE_LUI     7'b0110111
`define OPCODE_AUIPC   7'b0010111
`define OPCODE_SYSTEM  7'b1110011
`define OPCODE_FENCE   7'b0001111

`define FUNCT3_ADD   3'b000
`define FUNCT3_SLL   3'b001
`define FUNCT3_SLT   3'b010
`define FUNCT3_SLTU  3'b011
`define FUNCT3_XOR   3'b100
`define FUNCT3_SRA   3'b101
`define FUNCT3_OR    3'b110
`define FUNCT3_AND   3'b111

`define FUNCT3_EQ    3'b000
`define FUNCT3_NEQ   3'b001
`define FUNCT3_LT    3'b100
`define FUNCT3_GE    3'b101
`define FUNCT3_LTU   3'b110
`define FUNCT3_GEU   3'b111

`endif
